// File: bus_pkg.sv
`default_nettype none

package bus_pkg;
    typedef logic[31:0] addr_t;
    typedef logic[31:0] data_t;
    typedef logic[63:0] mtime_t;

    //clint register map
    localparam addr_t MSIP_ADDR = 32'h0200_0000;
    localparam addr_t MTIMECMP_LO_ADDR = 32'h0200_4000;
    localparam addr_t MTIMECMP_HI_ADDR = MTIMECMP_LO_ADDR + 32'd4;
    localparam addr_t MTIME_LO_ADDR = 32'h0200_BFF8;
    localparam addr_t MTIME_HI_ADDR = MTIME_LO_ADDR + 32'd4;

    //uart register map
    localparam addr_t UART_TXDATA_ADDR = 32'h1000_0000;
    localparam addr_t UART_RXDATA_ADDR = 32'h1000_0004;
    localparam addr_t UART_STATUS_ADDR = 32'h1000_0008;

    //uart status word
    localparam int STATUS_TX_BUSY_BIT = 0;
    localparam int STATUS_RX_VALID_BIT = 1;
    localparam int STATUS_RX_FRAME_ERR_BIT = 2;

    //compare never matches out of reset
    localparam mtime_t MTIMECMP_RESET = '1;
endpackage

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;
    typedef logic[7:0] uart_byte_t;

    localparam int SYS_FREQ = 8000000;
    localparam int UART_BAUD = 1000000;

    //clocks per bit
    localparam int FREQ_DIV = SYS_FREQ / UART_BAUD;

    typedef logic[$clog2(FREQ_DIV + 1) - 1:0] baud_cnt_t;

    //8N1 frame
    localparam int DATA_BITS = 8;

    typedef logic[$clog2(DATA_BITS) - 1:0] bit_idx_t;

    typedef enum logic[1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic[1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;
endpackage

`default_nettype wire

// File: clint.sv
`timescale 1ns/1ns
`default_nettype none

module clint(
        input logic clk,
        input logic rst_n,

        input logic msip_we,
        input logic mtimecmp_lo_we,
        input logic mtimecmp_hi_we,
        input logic mtime_lo_we,
        input logic mtime_hi_we,
        input bus_pkg::data_t wdata,

        output logic msip,
        output bus_pkg::mtime_t mtime,
        output bus_pkg::mtime_t mtimecmp,

        output logic int_software,
        output logic int_timer
    );

    //software interrupt pending bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip <= 1'b0;
        end else if (msip_we) begin
            msip <= wdata[0];
        end
    end

    assign int_software = msip;

    //free running, a written half replaces the increment for that cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (mtime_lo_we) begin
            mtime <= {mtime[63:32], wdata};
        end else if (mtime_hi_we) begin
            mtime <= {wdata, mtime[31:0]};
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= bus_pkg::MTIMECMP_RESET;
        end else begin
            if (mtimecmp_lo_we) begin
                mtimecmp[31:0] <= wdata;
            end

            if (mtimecmp_hi_we) begin
                mtimecmp[63:32] <= wdata;
            end
        end
    end

    //one cycle behind the compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_timer <= 1'b0;
        end else begin
            int_timer <= mtime >= mtimecmp;
        end
    end
endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx(
        input logic clk,
        input logic rst_n,

        input logic tx_start,
        input uart_pkg::uart_byte_t tx_byte,

        output logic tx_busy,
        output logic txd
    );

    uart_pkg::tx_state_t state;
    uart_pkg::baud_cnt_t baud_cnt;
    uart_pkg::bit_idx_t bit_idx;
    uart_pkg::uart_byte_t shift_reg;
    logic bit_end;

    assign bit_end = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::FREQ_DIV - 1);
    assign tx_busy = state != uart_pkg::TX_IDLE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx <= '0;
            txd <= 1'b1;
        end else begin
            if (state == uart_pkg::TX_IDLE || bit_end) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state <= uart_pkg::TX_START;
                        txd <= 1'b0;
                    end
                end

                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        txd <= shift_reg[0];
                    end
                end

                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::TX_STOP;
                            txd <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            //shift_reg moves on this same edge
                            txd <= shift_reg[1];
                        end
                    end
                end

                uart_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    //lsb first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::TX_IDLE && tx_start) begin
            shift_reg <= tx_byte;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        (state == uart_pkg::TX_IDLE) |-> txd);
endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx(
        input logic clk,
        input logic rst_n,

        input logic rxd,

        output logic rx_done,
        output uart_pkg::uart_byte_t rx_byte,
        output logic rx_frame_err
    );

    logic rxd_meta;
    logic rxd_sync;

    uart_pkg::rx_state_t state;
    uart_pkg::baud_cnt_t baud_cnt;
    uart_pkg::bit_idx_t bit_idx;
    uart_pkg::uart_byte_t shift_reg;
    logic mid_start;
    logic bit_end;

    //half a bit into the start bit, then whole bits from there
    assign mid_start = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::FREQ_DIV / 2 - 1);
    assign bit_end = baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::FREQ_DIV - 1);

    assign rx_byte = shift_reg;

    //line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uart_pkg::RX_IDLE;
            baud_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_done <= 1'b0;

            case (state)
                uart_pkg::RX_IDLE: begin
                    baud_cnt <= '0;

                    if (!rxd_sync) begin
                        state <= uart_pkg::RX_START;
                    end
                end

                uart_pkg::RX_START: begin
                    if (mid_start) begin
                        baud_cnt <= '0;
                        bit_idx <= '0;
                        //a short low pulse is not a start bit
                        state <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;

                        if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end

                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state <= uart_pkg::RX_IDLE;
                        rx_done <= 1'b1;
                        rx_frame_err <= !rxd_sync;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    //first bit received ends up in bit 0
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done);
endmodule

`default_nettype wire

// File: periph_bus.sv
`timescale 1ns/1ns
`default_nettype none

module periph_bus(
        input logic clk,
        input logic rst_n,

        input logic read_req,
        input bus_pkg::addr_t read_addr,
        output logic read_ack,
        output bus_pkg::data_t read_data,

        input logic write_req,
        input bus_pkg::addr_t write_addr,
        input bus_pkg::data_t write_data,
        output logic write_ack,

        input logic msip,
        input bus_pkg::mtime_t mtime,
        input bus_pkg::mtime_t mtimecmp,
        output logic msip_we,
        output logic mtimecmp_lo_we,
        output logic mtimecmp_hi_we,
        output logic mtime_lo_we,
        output logic mtime_hi_we,
        output bus_pkg::data_t wdata,

        input logic tx_busy,
        output logic tx_start,
        output uart_pkg::uart_byte_t tx_byte,

        input logic rx_done,
        input uart_pkg::uart_byte_t rx_byte,
        input logic rx_frame_err
    );

    logic read_req_d;
    logic write_req_d;
    logic read_new;
    logic write_new;
    logic tx_write;
    logic rx_read;

    uart_pkg::uart_byte_t rx_data;
    logic rx_valid;
    logic rx_err_flag;
    bus_pkg::data_t status;
    bus_pkg::data_t read_mux;

    //a request counts only on its first sampled cycle
    assign read_new = read_req && !read_req_d;
    assign write_new = write_req && !write_req_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_req_d <= 1'b0;
            write_req_d <= 1'b0;
            read_ack <= 1'b0;
            write_ack <= 1'b0;
        end else begin
            read_req_d <= read_req;
            write_req_d <= write_req;
            read_ack <= read_new;
            write_ack <= write_new;
        end
    end

    //clint registers load on the edge that raises write_ack
    assign msip_we = write_new && (write_addr == bus_pkg::MSIP_ADDR);
    assign mtimecmp_lo_we = write_new && (write_addr == bus_pkg::MTIMECMP_LO_ADDR);
    assign mtimecmp_hi_we = write_new && (write_addr == bus_pkg::MTIMECMP_HI_ADDR);
    assign mtime_lo_we = write_new && (write_addr == bus_pkg::MTIME_LO_ADDR);
    assign mtime_hi_we = write_new && (write_addr == bus_pkg::MTIME_HI_ADDR);
    assign wdata = write_data;

    assign tx_write = write_new && (write_addr == bus_pkg::UART_TXDATA_ADDR);
    assign rx_read = read_new && (read_addr == bus_pkg::UART_RXDATA_ADDR);

    //byte dropped while the transmitter is busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_write && !tx_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_write) begin
            tx_byte <= write_data[7:0];
        end
    end

    //sticky until software reads RXDATA
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
            rx_err_flag <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
            rx_err_flag <= rx_err_flag | rx_frame_err;
        end else if (rx_read) begin
            rx_valid <= 1'b0;
            rx_err_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_data <= rx_byte;
        end
    end

    always_comb begin
        status = '0;
        status[bus_pkg::STATUS_TX_BUSY_BIT] = tx_busy;
        status[bus_pkg::STATUS_RX_VALID_BIT] = rx_valid;
        status[bus_pkg::STATUS_RX_FRAME_ERR_BIT] = rx_err_flag;
    end

    //unmapped reads return zero
    always_comb begin
        case (read_addr)
            bus_pkg::MSIP_ADDR: read_mux = {31'd0, msip};
            bus_pkg::MTIMECMP_LO_ADDR: read_mux = mtimecmp[31:0];
            bus_pkg::MTIMECMP_HI_ADDR: read_mux = mtimecmp[63:32];
            bus_pkg::MTIME_LO_ADDR: read_mux = mtime[31:0];
            bus_pkg::MTIME_HI_ADDR: read_mux = mtime[63:32];
            bus_pkg::UART_RXDATA_ADDR: read_mux = {24'd0, rx_data};
            bus_pkg::UART_STATUS_ADDR: read_mux = status;
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (read_new) begin
            read_data <= read_mux;
        end
    end

    a_ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_ack && write_ack));

    a_tx_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy);
endmodule

`default_nettype wire

// File: periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module periph_top(
        input logic clk,
        input logic rst_n,

        input logic read_req,
        input bus_pkg::addr_t read_addr,
        output logic read_ack,
        output bus_pkg::data_t read_data,

        input logic write_req,
        input bus_pkg::addr_t write_addr,
        input bus_pkg::data_t write_data,
        output logic write_ack,

        output logic int_software,
        output logic int_timer,

        input logic rxd,
        output logic txd
    );

    //bus<->clint
    logic msip_we;
    logic mtimecmp_lo_we;
    logic mtimecmp_hi_we;
    logic mtime_lo_we;
    logic mtime_hi_we;
    bus_pkg::data_t wdata;
    logic msip;
    bus_pkg::mtime_t mtime;
    bus_pkg::mtime_t mtimecmp;

    //bus<->uart_tx
    logic tx_start;
    uart_pkg::uart_byte_t tx_byte;
    logic tx_busy;

    //bus<->uart_rx
    logic rx_done;
    uart_pkg::uart_byte_t rx_byte;
    logic rx_frame_err;

    periph_bus periph_bus_inst(.*);
    clint clint_inst(.*);
    uart_tx uart_tx_inst(.*);
    uart_rx uart_rx_inst(.*);
endmodule

`default_nettype wire

// File: tb_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_periph_top;
    localparam int OP_READ = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_PINS = 2;
    localparam int TABLE_MAX = 16;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT = 60;
    localparam int START_TIMEOUT = 200;
    localparam int TIMER_TIMEOUT = 400;
    localparam bus_pkg::addr_t UNMAPPED_ADDR = 32'h3000_0000;

    logic clk;
    logic rst_n;
    logic read_req;
    bus_pkg::addr_t read_addr;
    logic read_ack;
    bus_pkg::data_t read_data;
    logic write_req;
    bus_pkg::addr_t write_addr;
    bus_pkg::data_t write_data;
    logic write_ack;
    logic int_software;
    logic int_timer;
    logic rxd;
    logic txd;

    int op_kind [TABLE_MAX];
    bus_pkg::addr_t op_addr [TABLE_MAX];
    bus_pkg::data_t op_wdata [TABLE_MAX];
    bus_pkg::data_t op_expect [TABLE_MAX];
    bus_pkg::data_t op_mask [TABLE_MAX];
    int n_ops;

    int checks;
    int errors;
    int timeouts;
    integer seed;

    periph_top uut(.*);

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data);
        int n = 0;
        bit seen = 1'b0;
        @(posedge clk);
        write_req <= 1'b1;
        write_addr <= addr;
        write_data <= data;
        while (!seen && n < ACK_TIMEOUT) begin
            @(negedge clk);
            seen = write_ack;
            n++;
        end
        if (!seen) begin
            report_timeout($sformatf("write_ack at address %h", addr));
        end
        @(posedge clk);
        write_req <= 1'b0;
        //request was still high in the ack cycle
        @(negedge clk);
        check_value("write_ack", 32'd0, {31'd0, write_ack});
    endtask

    task automatic bus_read(input bus_pkg::addr_t addr, output bus_pkg::data_t data);
        int n = 0;
        bit seen = 1'b0;
        @(posedge clk);
        read_req <= 1'b1;
        read_addr <= addr;
        data = '0;
        while (!seen && n < ACK_TIMEOUT) begin
            @(negedge clk);
            seen = read_ack;
            n++;
        end
        if (seen) begin
            data = read_data;
        end else begin
            report_timeout($sformatf("read_ack at address %h", addr));
        end
        @(posedge clk);
        read_req <= 1'b0;
        @(negedge clk);
        check_value("read_ack", 32'd0, {31'd0, read_ack});
    endtask

    task automatic add_entry(input int kind, input bus_pkg::addr_t addr,
            input bus_pkg::data_t wdata, input bus_pkg::data_t expected,
            input bus_pkg::data_t mask);
        op_kind[n_ops] = kind;
        op_addr[n_ops] = addr;
        op_wdata[n_ops] = wdata;
        op_expect[n_ops] = expected;
        op_mask[n_ops] = mask;
        n_ops++;
    endtask

    //pin entries compare {txd, int_timer, int_software}
    task automatic load_table();
        n_ops = 0;
        add_entry(OP_PINS, '0, '0, 32'h4, 32'h7);
        add_entry(OP_READ, bus_pkg::MSIP_ADDR, '0, 32'h0, '1);
        add_entry(OP_READ, bus_pkg::MTIMECMP_LO_ADDR, '0, 32'hFFFF_FFFF, '1);
        add_entry(OP_READ, bus_pkg::MTIMECMP_HI_ADDR, '0, 32'hFFFF_FFFF, '1);
        add_entry(OP_READ, bus_pkg::UART_STATUS_ADDR, '0, 32'h0, '1);
        add_entry(OP_READ, UNMAPPED_ADDR, '0, 32'h0, '1);
        add_entry(OP_WRITE, UNMAPPED_ADDR, 32'hDEAD_BEEF, '0, '0);
        add_entry(OP_WRITE, bus_pkg::MSIP_ADDR, 32'h1, '0, '0);
        add_entry(OP_PINS, '0, '0, 32'h5, 32'h7);
        add_entry(OP_READ, bus_pkg::MSIP_ADDR, '0, 32'h1, '1);
        add_entry(OP_WRITE, bus_pkg::MSIP_ADDR, 32'h0, '0, '0);
        add_entry(OP_PINS, '0, '0, 32'h4, 32'h7);
        add_entry(OP_READ, bus_pkg::MSIP_ADDR, '0, 32'h0, '1);
    endtask

    task automatic apply_table();
        int i;
        bus_pkg::data_t data;
        for (i = 0; i < n_ops; i++) begin
            case (op_kind[i])
                OP_WRITE: bus_write(op_addr[i], op_wdata[i]);
                OP_READ: begin
                    bus_read(op_addr[i], data);
                    check_value($sformatf("read_data[%h]", op_addr[i]),
                        op_expect[i] & op_mask[i], data & op_mask[i]);
                end
                default: begin
                    @(negedge clk);
                    check_value("{txd,int_timer,int_software}", op_expect[i] & op_mask[i],
                        {29'd0, txd, int_timer, int_software} & op_mask[i]);
                end
            endcase
        end
    endtask

    task automatic wait_status_bit(input int bit_idx, input bit value,
            output bus_pkg::data_t status);
        int polls = 0;
        bit done = 1'b0;
        status = '0;
        while (!done && polls < POLL_LIMIT) begin
            bus_read(bus_pkg::UART_STATUS_ADDR, status);
            done = status[bit_idx] == value;
            polls++;
        end
        if (!done) begin
            report_timeout($sformatf("STATUS bit %0d to become %0b", bit_idx, value));
        end
    endtask

    task automatic test_timer();
        bus_pkg::data_t value;
        int n = 0;
        bit fired = 1'b0;
        bus_write(bus_pkg::MTIME_HI_ADDR, 32'd0);
        bus_write(bus_pkg::MTIME_LO_ADDR, 32'd0);
        bus_write(bus_pkg::MTIMECMP_HI_ADDR, 32'd0);
        bus_write(bus_pkg::MTIMECMP_LO_ADDR, 32'd300);
        while (!fired && n < TIMER_TIMEOUT) begin
            @(negedge clk);
            fired = int_timer;
            n++;
        end
        if (!fired) begin
            report_timeout("int_timer");
        end
        bus_read(bus_pkg::MTIME_LO_ADDR, value);
        check_value("mtime_lo at least 300", 32'd1, {31'd0, value >= 32'd300});
        bus_write(bus_pkg::MTIMECMP_HI_ADDR, 32'hFFFF_FFFF);
        @(negedge clk);
        check_value("int_timer", 32'd0, {31'd0, int_timer});
    endtask

    //samples each bit in its middle
    task automatic capture_tx_frame(output uart_pkg::uart_byte_t data, output bit stop_bit);
        int n = 0;
        int i;
        bit low = 1'b0;
        data = '0;
        stop_bit = 1'b0;
        while (!low && n < START_TIMEOUT) begin
            @(negedge clk);
            low = !txd;
            n++;
        end
        if (!low) begin
            report_timeout("start bit on txd");
        end else begin
            repeat (uart_pkg::FREQ_DIV / 2) @(negedge clk);
            check_value("txd start bit", 32'd0, {31'd0, txd});
            for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
                repeat (uart_pkg::FREQ_DIV) @(negedge clk);
                data[i] = txd;
            end
            repeat (uart_pkg::FREQ_DIV) @(negedge clk);
            stop_bit = txd;
        end
    endtask

    task automatic send_and_capture(input uart_pkg::uart_byte_t value);
        uart_pkg::uart_byte_t got;
        bit stop_bit;
        bus_pkg::data_t status;
        fork
            capture_tx_frame(got, stop_bit);
            begin
                bus_write(bus_pkg::UART_TXDATA_ADDR, {24'd0, value});
                bus_read(bus_pkg::UART_STATUS_ADDR, status);
                check_value("STATUS tx busy", 32'd1,
                    {31'd0, status[bus_pkg::STATUS_TX_BUSY_BIT]});
                //dropped while the transmitter is busy
                bus_write(bus_pkg::UART_TXDATA_ADDR, {24'd0, ~value});
            end
        join
        check_value("txd data", {24'd0, value}, {24'd0, got});
        check_value("txd stop bit", 32'd1, {31'd0, stop_bit});
        wait_status_bit(bus_pkg::STATUS_TX_BUSY_BIT, 1'b0, status);
    endtask

    task automatic send_rx_frame(input uart_pkg::uart_byte_t value, input bit stop_bit);
        int i;
        @(posedge clk);
        rxd <= 1'b0;
        repeat (uart_pkg::FREQ_DIV) @(posedge clk);
        for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
            rxd <= value[i];
            repeat (uart_pkg::FREQ_DIV) @(posedge clk);
        end
        rxd <= stop_bit;
        repeat (uart_pkg::FREQ_DIV) @(posedge clk);
        rxd <= 1'b1;
        repeat (2 * uart_pkg::FREQ_DIV) @(posedge clk);
    endtask

    task automatic receive_byte(input uart_pkg::uart_byte_t value, input bit stop_bit);
        bus_pkg::data_t status;
        bus_pkg::data_t data;
        send_rx_frame(value, stop_bit);
        wait_status_bit(bus_pkg::STATUS_RX_VALID_BIT, 1'b1, status);
        check_value("STATUS rx frame error", {31'd0, !stop_bit},
            {31'd0, status[bus_pkg::STATUS_RX_FRAME_ERR_BIT]});
        bus_read(bus_pkg::UART_RXDATA_ADDR, data);
        check_value("RXDATA", {24'd0, value}, data);
        bus_read(bus_pkg::UART_STATUS_ADDR, status);
        check_value("STATUS after RXDATA read", 32'd0, status);
    endtask

    initial begin
        int i;
        uart_pkg::uart_byte_t rx_value;
        clk = 1'b0;
        rst_n <= 1'b0;
        read_req <= 1'b0;
        read_addr <= '0;
        write_req <= 1'b0;
        write_addr <= '0;
        write_data <= '0;
        rxd <= 1'b1;
        seed = 32'h9874;
        checks = 0;
        errors = 0;
        timeouts = 0;
        load_table();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        apply_table();
        test_timer();
        send_and_capture(8'hA5);
        send_and_capture(8'h3C);

        for (i = 0; i < 4; i++) begin
            rx_value = uart_pkg::uart_byte_t'($random(seed));
            receive_byte(rx_value, 1'b1);
        end

        //low stop bit
        rx_value = uart_pkg::uart_byte_t'($random(seed));
        receive_byte(rx_value, 1'b0);

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: periph_top.f
bus_pkg.sv
uart_pkg.sv
clint.sv
uart_tx.sv
uart_rx.sv
periph_bus.sv
periph_top.sv
tb_periph_top.sv
